/* cache/cache_tag_store.sv */
`default_nettype none

`include "cache_params.svh"

module cache_tag_store (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire cache_pkg::addr_t      lookup_addr,
    output logic                       hit,
    output cache_pkg::line_t           rdata,
    input  wire logic                  fill_valid,
    input  wire cache_pkg::addr_t      fill_addr,
    input  wire cache_pkg::line_t      fill_data,
    input  wire logic                  wr_valid,
    input  wire cache_pkg::addr_t      wr_addr,
    input  wire logic [`WORD_SIZE-1:0] wr_word
);
    import cache_pkg::*;

    logic [`CACHE_LINES-1:0] valid_q;
    logic [`TAG_BITS-1:0]    tag_q [`CACHE_LINES];
    line_t                   line_q [`CACHE_LINES];
    logic                    wr_hit;

    // combinational lookup
    assign hit = valid_q[lookup_addr.index] &&
                 (tag_q[lookup_addr.index] == lookup_addr.tag);
    assign rdata = line_q[lookup_addr.index];

    // word write only lands on a resident line
    assign wr_hit = valid_q[wr_addr.index] &&
                    (tag_q[wr_addr.index] == wr_addr.tag);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fill_addr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_q[fill_addr.index]  <= fill_addr.tag;
            line_q[fill_addr.index] <= fill_data;
        end
        if (wr_valid && wr_hit) begin
            line_q[wr_addr.index].words[wr_addr.offset] <= wr_word; // one lane
        end
    end

endmodule

`default_nettype wire

/* cache/dcache.sv */
`default_nettype none

module dcache (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire cache_pkg::data_req_t data_req,
    output logic                      data_ready,
    output cache_pkg::core_resp_t     data_resp,
    output cache_pkg::mem_req_t       line_req,
    input  wire logic                 grant,
    input  wire cache_pkg::mem_resp_t fill
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_FILL,
        S_WRITE
    } state_t;

    state_t state_q;
    addr_t  addr_q;
    logic [$bits(data_req.wdata)-1:0] wdata_q;
    logic   resp_valid_q;
    logic [$bits(data_resp.data)-1:0] resp_data_q;
    logic   lookup_hit;
    line_t  lookup_line;
    logic   accept;
    logic   fill_take;
    logic   write_done;

    assign data_ready = (state_q == S_IDLE);
    assign accept     = data_req.valid && data_ready;
    assign fill_take  = fill.valid && (state_q == S_WAIT_FILL);
    assign write_done = grant && (state_q == S_WRITE);

    // write hits update the line at acceptance, misses never allocate
    cache_tag_store u_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .lookup_addr (data_req.addr),
        .hit         (lookup_hit),
        .rdata       (lookup_line),
        .fill_valid  (fill_take),
        .fill_addr   (addr_q),
        .fill_data   (fill.data),
        .wr_valid    (accept && data_req.write),
        .wr_addr     (data_req.addr),
        .wr_word     (data_req.wdata)
    );

    ////////////////////////////////////////
    // control

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q      <= S_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept && data_req.write) begin
                        state_q <= S_WRITE;
                    end else if (accept && lookup_hit) begin
                        resp_valid_q <= 1'b1;
                    end else if (accept) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (grant) begin
                        state_q <= S_WAIT_FILL;
                    end
                end
                S_WAIT_FILL: begin
                    if (fill_take) begin
                        state_q      <= S_IDLE;
                        resp_valid_q <= 1'b1;
                    end
                end
                S_WRITE: begin
                    if (write_done) begin
                        state_q      <= S_IDLE;
                        resp_valid_q <= 1'b1;   // echo of the written word
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // payload

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= data_req.addr;
            wdata_q <= data_req.wdata;
        end
        if (accept) begin
            resp_data_q <= lookup_line.words[data_req.addr.offset];
        end else if (fill_take) begin
            resp_data_q <= fill.data.words[addr_q.offset];
        end else if (write_done) begin
            resp_data_q <= wdata_q;
        end
    end

    assign data_resp.valid = resp_valid_q;
    assign data_resp.data  = resp_data_q;

    always_comb begin
        line_req      = '0;
        line_req.addr = addr_q;
        if (state_q == S_WRITE) begin
            line_req.valid                     = 1'b1;
            line_req.write                     = 1'b1;
            line_req.data.words[addr_q.offset] = wdata_q; // own lane only
        end else if (state_q == S_REQ) begin
            line_req.valid       = 1'b1;
            line_req.addr.offset = '0;
        end
    end

endmodule

`default_nettype wire

/* cache/icache.sv */
`default_nettype none

module icache (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire cache_pkg::fetch_req_t fetch_req,
    output logic                       fetch_ready,
    output cache_pkg::core_resp_t      fetch_resp,
    output cache_pkg::mem_req_t        line_req,
    input  wire logic                  grant,
    input  wire cache_pkg::mem_resp_t  fill
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_FILL
    } state_t;

    state_t state_q;
    addr_t  req_addr_q;
    logic   resp_valid_q;
    logic [$bits(fetch_resp.data)-1:0] resp_data_q;
    logic   lookup_hit;
    line_t  lookup_line;
    logic   accept;
    logic   fill_take;

    assign fetch_ready = (state_q == S_IDLE);
    assign accept      = fetch_req.valid && fetch_ready;
    assign fill_take   = fill.valid && (state_q == S_WAIT_FILL);

    cache_tag_store u_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .lookup_addr (fetch_req.addr),
        .hit         (lookup_hit),
        .rdata       (lookup_line),
        .fill_valid  (fill_take),
        .fill_addr   (req_addr_q),
        .fill_data   (fill.data),
        .wr_valid    (1'b0),        // read only
        .wr_addr     (req_addr_q),
        .wr_word     ('0)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q      <= S_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept && lookup_hit) begin
                        resp_valid_q <= 1'b1;
                    end else if (accept) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (grant) begin
                        state_q <= S_WAIT_FILL;
                    end
                end
                S_WAIT_FILL: begin
                    if (fill_take) begin
                        state_q      <= S_IDLE;
                        resp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= fetch_req.addr;
            resp_data_q <= lookup_line.words[fetch_req.addr.offset];
        end else if (fill_take) begin
            resp_data_q <= fill.data.words[req_addr_q.offset]; // missed word
        end
    end

    assign fetch_resp.valid = resp_valid_q;
    assign fetch_resp.data  = resp_data_q;

    always_comb begin
        line_req             = '0;
        line_req.valid       = (state_q == S_REQ);
        line_req.addr        = req_addr_q;
        line_req.addr.offset = '0;      // whole line
    end

endmodule

`default_nettype wire

/* cache_subsystem.f */
+incdir+common
common/cache_pkg.sv
cache/cache_tag_store.sv
cache/icache.sv
cache/dcache.sv
src/mem_arbiter.sv
src/cache_subsystem.sv
verification/cache_subsystem_checker.sv
verification/tb_mem_model.sv
verification/tb_cache_subsystem.sv

/* common/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word and line widths
`define WORD_SIZE   16
`define QWORD_SIZE  64
`define LINE_WORDS  4

// address split, tag | index | offset
`define OFFSET_BITS 2
`define INDEX_BITS  3
`define TAG_BITS    11

// direct mapped, one line per index
`define CACHE_LINES 8

// outstanding requests on the memory port
`define MEM_CREDITS 2

`endif

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    // word address
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } addr_t;

    // one line, as memory moves it or as separate words
    typedef union packed {
        logic [`QWORD_SIZE-1:0]                 qword;
        logic [`LINE_WORDS-1:0][`WORD_SIZE-1:0] words;
    } line_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        addr_t                  addr;
        logic [`WORD_SIZE-1:0]  wdata;
    } data_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`WORD_SIZE-1:0]  data;
    } core_resp_t;

    // reads are line aligned, a write word sits in lane addr.offset
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        line_t data;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_resp_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_subsystem \
    -f cache_subsystem.f \
    -o sim_cache_subsystem

./obj_dir/sim_cache_subsystem | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"

/* src/cache_subsystem.sv */
`default_nettype none

module cache_subsystem (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire cache_pkg::fetch_req_t fetch_req,
    output logic                       fetch_ready,
    output cache_pkg::core_resp_t      fetch_resp,
    input  wire cache_pkg::data_req_t  data_req,
    output logic                       data_ready,
    output cache_pkg::core_resp_t      data_resp,
    output cache_pkg::mem_req_t        mem_req,
    input  wire logic                  mem_credit,
    input  wire cache_pkg::mem_resp_t  mem_resp
);
    import cache_pkg::*;

    mem_req_t  i_line_req;
    mem_req_t  d_line_req;
    logic      i_grant;
    logic      d_grant;
    mem_resp_t i_fill;
    mem_resp_t d_fill;

    icache u_icache (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .fetch_resp  (fetch_resp),
        .line_req    (i_line_req),
        .grant       (i_grant),
        .fill        (i_fill)
    );

    dcache u_dcache (
        .clk        (clk),
        .reset_n    (reset_n),
        .data_req   (data_req),
        .data_ready (data_ready),
        .data_resp  (data_resp),
        .line_req   (d_line_req),
        .grant      (d_grant),
        .fill       (d_fill)
    );

    // shared memory port
    mem_arbiter u_arbiter (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_line_req (i_line_req),
        .d_line_req (d_line_req),
        .i_grant    (i_grant),
        .d_grant    (d_grant),
        .i_fill     (i_fill),
        .d_fill     (d_fill),
        .mem_req    (mem_req),
        .mem_credit (mem_credit),
        .mem_resp   (mem_resp)
    );

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`default_nettype none

`include "cache_params.svh"

module mem_arbiter (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire cache_pkg::mem_req_t  i_line_req,
    input  wire cache_pkg::mem_req_t  d_line_req,
    output logic                      i_grant,
    output logic                      d_grant,
    output cache_pkg::mem_resp_t      i_fill,
    output cache_pkg::mem_resp_t      d_fill,
    output cache_pkg::mem_req_t       mem_req,
    input  wire logic                 mem_credit,
    input  wire cache_pkg::mem_resp_t mem_resp
);

    localparam int CW = $clog2(`MEM_CREDITS + 1);
    localparam int PW = (`MEM_CREDITS > 1) ? $clog2(`MEM_CREDITS) : 1;

    logic [CW-1:0] credit_q;
    logic          has_credit;
    logic          spend;
    logic          push;
    logic          pop;
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] oq_count_q;
    logic          owner_q [`MEM_CREDITS];   // 1 = dcache
    logic          head_is_data;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(`MEM_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // grant, data side first

    assign has_credit = (credit_q != '0);
    assign d_grant    = d_line_req.valid && has_credit;
    assign i_grant    = i_line_req.valid && has_credit && !d_line_req.valid;
    assign spend      = d_grant || i_grant;

    always_comb begin
        mem_req = '0;
        if (d_grant) begin
            mem_req = d_line_req;
        end else if (i_grant) begin
            mem_req = i_line_req;
        end
    end

    ////////////////////////////////////////
    // credits

    always_ff @(posedge clk) begin
        if (reset_n) begin
            credit_q <= CW'(`MEM_CREDITS);
        end else if (spend && !mem_credit) begin
            credit_q <= credit_q - 1'b1;
        end else if (!spend && mem_credit) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // owner queue, one entry per read in flight

    assign push = spend && !mem_req.write;  // writes return nothing
    assign pop  = mem_resp.valid && (oq_count_q != '0);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            oq_count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                oq_count_q <= oq_count_q + 1'b1;
            end else if (!push && pop) begin
                oq_count_q <= oq_count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            owner_q[wr_ptr_q] <= d_grant;
        end
    end

    assign head_is_data = owner_q[rd_ptr_q];

    // fill goes straight through to the oldest reader
    always_comb begin
        i_fill       = mem_resp;
        d_fill       = mem_resp;
        i_fill.valid = pop && !head_is_data;
        d_fill.valid = pop && head_is_data;
    end

endmodule

`default_nettype wire

/* verification/cache_subsystem_checker.sv */
`default_nettype none

`include "cache_params.svh"

module cache_subsystem_checker (
    input wire logic                                  clk,
    input wire logic                                  reset_n,
    input wire logic                                  grant,
    input wire logic                                  push,
    input wire logic                                  mem_req_valid,
    input wire logic                                  mem_credit,
    input wire logic [$clog2(`MEM_CREDITS + 1)-1:0]  credit,
    input wire logic [$clog2(`MEM_CREDITS + 1)-1:0]  oq_count
);

    localparam int CW = $clog2(`MEM_CREDITS + 1);

    logic [CW-1:0] port_credit_q;   // counted from the memory port alone

    always_ff @(posedge clk) begin
        if (reset_n) begin
            port_credit_q <= CW'(`MEM_CREDITS);
        end else begin
            port_credit_q <= port_credit_q + CW'(mem_credit) - CW'(mem_req_valid);
        end
    end

    no_grant_without_credit: assert property (@(posedge clk) disable iff (reset_n)
        grant |-> port_credit_q != '0)
        else $error("grant given with zero credits");

    credit_in_range: assert property (@(posedge clk) disable iff (reset_n)
        credit <= `MEM_CREDITS)
        else $error("credit count above limit");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset_n)
        push |-> oq_count < `MEM_CREDITS)
        else $error("owner queue pushed while full");

    // first cycle out of reset
    idle_after_reset: assert property (@(posedge clk)
        $fell(reset_n) |-> !mem_req_valid)
        else $error("memory request right after reset");

endmodule

bind mem_arbiter cache_subsystem_checker u_checker (
    .clk           (clk),
    .reset_n       (reset_n),
    .grant         (i_grant || d_grant),
    .push          (push),
    .mem_req_valid (mem_req.valid),
    .mem_credit    (mem_credit),
    .credit        (credit_q),
    .oq_count      (oq_count_q)
);

`default_nettype wire

/* verification/tb_cache_subsystem.sv */
`default_nettype none

module tb_cache_subsystem;
    import cache_pkg::*;

    localparam int LIMIT = 200;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       hold;
    fetch_req_t fetch_req;
    data_req_t  data_req;
    logic       fetch_ready;
    logic       data_ready;
    core_resp_t fetch_resp;
    core_resp_t data_resp;
    mem_req_t   mem_req;
    logic       mem_credit;
    mem_resp_t  mem_resp;
    int         pending;
    logic       overflow;

    string       test_name;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    logic [15:0] written [logic [15:0]];   // word address to last stored value

    always #2 clk = ~clk;

    cache_subsystem uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .fetch_resp  (fetch_resp),
        .data_req    (data_req),
        .data_ready  (data_ready),
        .data_resp   (data_resp),
        .mem_req     (mem_req),
        .mem_credit  (mem_credit),
        .mem_resp    (mem_resp)
    );

    tb_mem_model u_mem (
        .clk        (clk),
        .reset_n    (reset_n),
        .hold       (hold),
        .mem_req    (mem_req),
        .mem_credit (mem_credit),
        .mem_resp   (mem_resp),
        .pending    (pending),
        .overflow   (overflow)
    );

    ////////////////////////////////////////
    // helpers

    function automatic logic [15:0] expected_word(input logic [15:0] a);
        if (written.exists(a)) begin
            return written[a];
        end
        return a ^ 16'h5a5a;
    endfunction

    task automatic check_value(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished with %0d errors", test_name, errors - test_errors);
    endtask

    // one request on either core port
    // lat counts cycles from acceptance
    task automatic port_access(input bit on_data, input bit wr, input logic [15:0] a,
                               input logic [15:0] wd, output logic [15:0] d, output int lat);
        int n;
        @(negedge clk);
        if (on_data) begin
            data_req.valid = 1'b1;
            data_req.write = wr;
            data_req.addr  = a;
            data_req.wdata = wd;
        end else begin
            fetch_req.valid = 1'b1;
            fetch_req.addr  = a;
        end
        n = 0;
        while (!(on_data ? data_ready : fetch_ready) && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(on_data ? data_ready : fetch_ready)) begin
            errors++;
            $display("%s: port never became ready for address %h", test_name, a);
        end
        @(negedge clk);
        if (on_data) begin
            data_req.valid = 1'b0;
        end else begin
            fetch_req.valid = 1'b0;
        end
        lat = 1;
        while (!(on_data ? data_resp.valid : fetch_resp.valid) && lat < LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!(on_data ? data_resp.valid : fetch_resp.valid)) begin
            errors++;
            $display("%s: no response in time for address %h", test_name, a);
        end
        d = on_data ? data_resp.data : fetch_resp.data;
    endtask

    task automatic read_and_check(input bit on_data, input logic [15:0] a, output int lat);
        logic [15:0] d;
        port_access(on_data, 1'b0, a, 16'h0, d, lat);
        check_value($sformatf("%s read %h", on_data ? "data" : "fetch", a),
                    expected_word(a), d);
    endtask

    task automatic store_word(input logic [15:0] a, input logic [15:0] wd);
        logic [15:0] d;
        int          lat;
        written[a] = wd;
        port_access(1'b1, 1'b1, a, wd, d, lat);
        check_value($sformatf("write echo %h", a), wd, d);
    endtask

    task automatic wait_mem_idle();
        int n = 0;
        while (pending != 0 && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            errors++;
            $display("%s: memory model still busy after %0d cycles", test_name, n);
        end
    endtask

    ////////////////////////////////////////
    // tests

    task automatic fetch_miss_then_hit();
        int lat;
        begin_test("fetch_miss_then_hit");
        read_and_check(1'b0, 16'h0121, lat);
        for (int k = 0; k < 4; k++) begin
            if (k != 1) begin
                read_and_check(1'b0, 16'h0120 + 16'(k), lat);
                check_value("hit latency", 16'd1, 16'(lat));
            end
        end
        end_test();
    endtask

    task automatic write_through_read();
        int lat;
        begin_test("write_through_read");
        read_and_check(1'b1, 16'h0240, lat);   // line now resident
        store_word(16'h0242, 16'hbeef);
        read_and_check(1'b1, 16'h0242, lat);
        check_value("hit latency", 16'd1, 16'(lat));
        wait_mem_idle();
        check_value("memory word", 16'hbeef, u_mem.mem_q[16'h0242]);
        end_test();
    endtask

    task automatic write_no_allocate();
        int lat;
        begin_test("write_no_allocate");
        store_word(16'h0363, 16'h1234);
        read_and_check(1'b1, 16'h0363, lat);
        check_value("read missed", 16'd1, {15'd0, lat > 1});
        end_test();
    endtask

    task automatic conflict_eviction();
        int lat;
        begin_test("conflict_eviction");
        for (int r = 0; r < 3; r++) begin
            read_and_check(1'b0, 16'h0404, lat);
            read_and_check(1'b0, 16'h0804, lat);
            check_value("fetch evicted", 16'd1, {15'd0, lat > 1});
            read_and_check(1'b1, 16'h0405, lat);
            read_and_check(1'b1, 16'h0805, lat);
            check_value("data evicted", 16'd1, {15'd0, lat > 1});
        end
        end_test();
    endtask

    task automatic concurrent_misses();
        logic [15:0] ia;
        logic [15:0] da;
        int          li;
        int          ld;
        begin_test("concurrent_misses");
        for (int r = 0; r < 4; r++) begin
            ia = 16'h1000 | 16'($urandom() & 32'h0fff);
            da = 16'h2000 | 16'($urandom() & 32'h0fff);
            fork
                read_and_check(1'b0, ia, li);
                read_and_check(1'b1, da, ld);
            join
        end
        end_test();
    endtask

    task automatic credit_backpressure();
        int li;
        int ld;
        begin_test("credit_backpressure");
        @(negedge clk);
        hold = 1'b1;
        fork
            begin
                store_word(16'h3005, 16'h5555);
                read_and_check(1'b1, 16'h3208, ld);
            end
            read_and_check(1'b0, 16'h3100, li);
            begin
                repeat (20) @(negedge clk);
                check_value("requests at model", 16'd2, 16'(pending));
                check_value("data port stalled", 16'd0, {15'd0, data_ready});
                check_value("fetch port stalled", 16'd0, {15'd0, fetch_ready});
                hold = 1'b0;
            end
        join
        wait_mem_idle();
        check_value("memory word", 16'h5555, u_mem.mem_q[16'h3005]);
        check_value("model overflow", 16'd0, {15'd0, overflow});
        read_and_check(1'b1, 16'h3005, ld);   // not allocated by the write
        check_value("read missed", 16'd1, {15'd0, ld > 1});
        end_test();
    endtask

    initial begin
        void'($urandom(32'h2c8edb2e));
        reset_n   = 1'b1;
        hold      = 1'b0;
        fetch_req = '0;
        data_req  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;

        fetch_miss_then_hit();
        write_through_read();
        write_no_allocate();
        conflict_eviction();
        concurrent_misses();
        credit_backpressure();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_mem_model.sv */
`default_nettype none

`include "cache_params.svh"

module tb_mem_model (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire logic                 hold,
    input  wire cache_pkg::mem_req_t  mem_req,
    output logic                      mem_credit,
    output cache_pkg::mem_resp_t      mem_resp,
    output int                        pending,
    output logic                      overflow
);
    import cache_pkg::*;

    logic [`WORD_SIZE-1:0] mem_q [1 << `WORD_SIZE];
    mem_req_t              req_q [$];
    int unsigned           due_q [$];
    int unsigned           cycle = 0;
    int                    pushed = 0;
    int                    popped = 0;

    assign pending = pushed - popped;

    initial begin
        mem_credit = 1'b0;
        mem_resp   = '0;
        overflow   = 1'b0;
        for (int a = 0; a < (1 << `WORD_SIZE); a++) begin
            mem_q[a] = 16'(a) ^ 16'h5a5a;
        end
    end

    // capture requests, each with its own random delay
    always @(posedge clk) begin
        if (reset_n) begin
            req_q.delete();
            due_q.delete();
            cycle    = 0;
            pushed   = 0;
            overflow = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (mem_req.valid) begin
                req_q.push_back(mem_req);
                due_q.push_back(cycle + $urandom_range(4, 1));
                pushed++;
                if (req_q.size() > `MEM_CREDITS) begin
                    overflow = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // complete in order, one per cycle
    always @(negedge clk) begin
        mem_req_t  head;
        mem_resp_t rsp;
        mem_credit = 1'b0;
        mem_resp   = '0;
        rsp        = '0;
        if (reset_n) begin
            popped = 0;
        end else if (!hold && req_q.size() != 0 && due_q[0] <= cycle) begin
            head = req_q.pop_front();
            void'(due_q.pop_front());
            popped++;
            if (head.write) begin
                mem_q[head.addr] = head.data.words[head.addr.offset]; // one lane
            end else begin
                for (int k = 0; k < `LINE_WORDS; k++) begin
                    rsp.data.words[k] = mem_q[{head.addr.tag, head.addr.index, `OFFSET_BITS'(k)}];
                end
                rsp.valid = 1'b1;
            end
            mem_credit = 1'b1;  // credit rides with the response
            mem_resp   = rsp;
        end
    end

endmodule

`default_nettype wire
